/* list.f */
rtl/periph_pkg.sv
rtl/periph_bus_if.sv
rtl/address_decoder.sv
rtl/dsp_mult.sv
rtl/board_io.sv
rtl/cop_ram.sv
rtl/bus_arbiter.sv
rtl/periph_subsystem.sv
verification/periph_bus_checker.sv
verification/periph_subsystem_tb.sv

/* rtl/address_decoder.sv */
// address decoder for the peripheral bus
// registers the region of each request, one sel pulse per request
// and a write strobe for the addressed peripheral

`timescale 1ns/1ps

module address_decoder (
    input  logic                vdp_clk,
    input  logic                vdp_reset,
    periph_bus_if.periph_side   bus,
    output periph_pkg::region_t region,
    output logic                sel,
    output logic                dsp_write,
    output logic                status_write,
    output logic                pad_write,
    output logic                cop_write
);

    periph_pkg::region_t next_region;
    logic                served;
    logic                sel_write;
    logic                start;

    // address bits 19:16 pick the region
    always_comb begin
        case (bus.address[19:16])
            periph_pkg::region_dsp,
            periph_pkg::region_status,
            periph_pkg::region_pad,
            periph_pkg::region_cop: begin
                next_region = periph_pkg::region_t'(bus.address[19:16]);
            end
            default: begin
                next_region = periph_pkg::region_none;
            end
        endcase
    end

    // first cycle of a request not yet handed out
    assign start = bus.valid && !served;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            served    <= 1'b0;
            sel       <= 1'b0;
            sel_write <= 1'b0;
            region    <= periph_pkg::region_none;
        end else begin
            sel       <= start;
            sel_write <= start && (bus.wstrb != '0);

            if (start) begin
                served <= 1'b1;
                region <= next_region;
            end else if (!bus.valid) begin
                // request finished, ready for the next one
                served <= 1'b0;
            end
        end
    end

    // per-peripheral write strobes
    assign dsp_write    = sel_write && (region == periph_pkg::region_dsp);
    assign status_write = sel_write && (region == periph_pkg::region_status);
    assign pad_write    = sel_write && (region == periph_pkg::region_pad);
    assign cop_write    = sel_write && (region == periph_pkg::region_cop);

endmodule

/* rtl/board_io.sv */
// board IO registers
// status LEDs (bit 0 red, bit 1 blue)
// gamepad control (bit 0 latch, bit 1 clock) and the button shift register

`timescale 1ns/1ps

module board_io (
    input  logic              vdp_clk,
    input  logic              vdp_reset,
    periph_bus_if.periph_side bus,
    input  logic              status_write,
    input  logic              pad_write,
    input  logic              btn_1,
    input  logic              btn_2,
    input  logic              btn_3,
    output logic              led_r,
    output logic              led_b,
    output logic [1:0]        status,
    output logic              pad_bit
);

    logic [1:0]  pad_ctrl;
    logic        pad_clk_r;
    logic        pad_latch;
    logic        pad_clk;
    logic        pad_clk_rise;
    logic [15:0] pad_shift;

    assign led_r = status[0];
    assign led_b = status[1];

    assign pad_latch    = pad_ctrl[0];
    assign pad_clk      = pad_ctrl[1];
    assign pad_clk_rise = pad_clk && !pad_clk_r;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status    <= periph_pkg::status_reset_value;
            pad_ctrl  <= 2'b00;
            pad_clk_r <= 1'b0;
        end else begin
            if (status_write) begin
                status <= bus.write_data[1:0];
            end

            if (pad_write) begin
                pad_ctrl <= bus.write_data[1:0];
            end

            // previous pad clock for edge detection
            pad_clk_r <= pad_clk;
        end
    end

    // buttons stand in for a real pad: left, right and B
    always_ff @(posedge vdp_clk) begin
        if (pad_clk_rise) begin
            pad_shift <= {1'b0, pad_shift[15:1]};
        end else if (pad_latch) begin
            pad_shift <= {8'h00, btn_1, btn_3, 5'b00000, btn_2};
        end
    end

    assign pad_bit = pad_shift[0];

endmodule

/* rtl/bus_arbiter.sv */
// read data mux and ready generation for the cpu bus
// one ready pulse per sel, read word picked by the decoded region

`timescale 1ns/1ps

module bus_arbiter (
    input  logic                              vdp_clk,
    input  logic                              vdp_reset,
    input  periph_pkg::region_t               region,
    input  logic                              sel,
    input  logic [periph_pkg::data_width-1:0] dsp_result,
    input  logic [1:0]                        status,
    input  logic                              pad_bit,
    output logic                              cpu_ready,
    output logic [periph_pkg::data_width-1:0] cpu_read_data
);

    logic [periph_pkg::data_width-1:0] read_word;

    always_comb begin
        case (region)
            periph_pkg::region_dsp: begin
                read_word = dsp_result;
            end
            periph_pkg::region_status: begin
                read_word = {{(periph_pkg::data_width-2){1'b0}}, status};
            end
            periph_pkg::region_pad: begin
                read_word = {{(periph_pkg::data_width-1){1'b0}}, pad_bit};
            end
            // copper RAM is write only from the cpu side
            default: begin
                read_word = '0;
            end
        endcase
    end

    // writes complete the same way, read word is ignored
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            cpu_ready <= 1'b0;
        end else begin
            cpu_ready <= sel;
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (sel) begin
            cpu_read_data <= read_word;
        end
    end

endmodule

/* rtl/cop_ram.sv */
// copper RAM, 2048 words of 16 bits
// cpu write port, registered read port for the display engine

`timescale 1ns/1ps

module cop_ram (
    input  logic                                vdp_clk,
    periph_bus_if.periph_side                   bus,
    input  logic                                cop_write,
    input  logic                                cop_read_en,
    input  logic [periph_pkg::cop_addr_width-1:0] cop_read_address,
    output logic [periph_pkg::cop_data_width-1:0] cop_read_data
);

    logic [periph_pkg::cop_data_width-1:0] mem [0:(1 << periph_pkg::cop_addr_width)-1];
    logic [periph_pkg::cop_addr_width-1:0] write_address;

    // word pair per cpu word, wstrb bit 2 picks the upper half
    assign write_address = {bus.address[11:2], bus.wstrb[2]};

    always_ff @(posedge vdp_clk) begin
        if (cop_write) begin
            mem[write_address] <= bus.write_data[periph_pkg::cop_data_width-1:0];
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (cop_read_en) begin
            cop_read_data <= mem[cop_read_address];
        end
    end

endmodule

/* rtl/dsp_mult.sv */
// memory-mapped signed 16x16 multiplier
// operand a at word 0, operand b at word 1, registered 32-bit product

`timescale 1ns/1ps

module dsp_mult (
    input  logic                            vdp_clk,
    periph_bus_if.periph_side               bus,
    input  logic                            dsp_write,
    output logic [periph_pkg::data_width-1:0] dsp_result
);

    logic signed [15:0] mult_a;
    logic signed [15:0] mult_b;

    // flat enables keep the operand registers inside the hard multiplier
    always_ff @(posedge vdp_clk) begin
        if (dsp_write && !bus.address[2]) begin
            mult_a <= bus.write_data[15:0];
        end

        if (dsp_write && bus.address[2]) begin
            mult_b <= bus.write_data[15:0];
        end

        // signed product, recomputed every cycle
        dsp_result <= mult_a * mult_b;
    end

endmodule

/* rtl/periph_bus_if.sv */
// cpu request bundle shared by the decoder and the peripherals
// cpu_side drives the request, periph_side only observes it

`timescale 1ns/1ps

interface periph_bus_if;

    logic [periph_pkg::addr_width-1:0]   address;
    logic [periph_pkg::data_width-1:0]   write_data;
    // nonzero strobes mark a write
    logic [periph_pkg::data_width/8-1:0] wstrb;
    logic                                valid;

    modport cpu_side (
        output address,
        output write_data,
        output wstrb,
        output valid
    );

    modport periph_side (
        input address,
        input write_data,
        input wstrb,
        input valid
    );

endinterface

/* rtl/periph_pkg.sv */
// shared definitions for the peripheral subsystem
// bus widths, copper RAM geometry, decoded address regions
// and the LED status value after reset

package periph_pkg;

    // cpu bus
    localparam int addr_width = 24;
    localparam int data_width = 32;

    // copper RAM, one 16-bit word per address
    localparam int cop_addr_width = 11;
    localparam int cop_data_width = 16;

    // red LED on, blue LED off
    localparam logic [1:0] status_reset_value = 2'b01;

    // region selected by address bits 19:16
    // any value not listed here is unmapped
    typedef enum logic [3:0] {
        region_none   = 4'd0,
        region_dsp    = 4'd1,
        region_status = 4'd2,
        region_pad    = 4'd3,
        region_cop    = 4'd4
    } region_t;

endpackage

/* rtl/periph_subsystem.sv */
// peripheral subsystem top level
// cpu bus decoder, dsp multiplier, board IO, copper RAM and bus arbiter

`timescale 1ns/1ps

module periph_subsystem (
    input  logic                                  vdp_clk,
    input  logic                                  vdp_reset,

    // cpu memory bus
    input  logic [periph_pkg::addr_width-1:0]     cpu_address,
    input  logic [periph_pkg::data_width-1:0]     cpu_write_data,
    input  logic [periph_pkg::data_width/8-1:0]   cpu_wstrb,
    input  logic                                  cpu_valid,
    output logic                                  cpu_ready,
    output logic [periph_pkg::data_width-1:0]     cpu_read_data,

    // board
    input  logic                                  btn_1,
    input  logic                                  btn_2,
    input  logic                                  btn_3,
    output logic                                  led_r,
    output logic                                  led_b,

    // display engine side of the copper RAM
    input  logic                                  cop_read_en,
    input  logic [periph_pkg::cop_addr_width-1:0] cop_read_address,
    output logic [periph_pkg::cop_data_width-1:0] cop_read_data
);

    periph_bus_if periph_bus ();

    periph_pkg::region_t               region;
    logic                              sel;
    logic                              dsp_write;
    logic                              status_write;
    logic                              pad_write;
    logic                              cop_write;
    logic [periph_pkg::data_width-1:0] dsp_result;
    logic [1:0]                        status;
    logic                              pad_bit;

    assign periph_bus.address    = cpu_address;
    assign periph_bus.write_data = cpu_write_data;
    assign periph_bus.wstrb      = cpu_wstrb;
    assign periph_bus.valid      = cpu_valid;

    address_decoder address_decoder_i (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .bus          (periph_bus),
        .region       (region),
        .sel          (sel),
        .dsp_write    (dsp_write),
        .status_write (status_write),
        .pad_write    (pad_write),
        .cop_write    (cop_write)
    );

    dsp_mult dsp_mult_i (
        .vdp_clk    (vdp_clk),
        .bus        (periph_bus),
        .dsp_write  (dsp_write),
        .dsp_result (dsp_result)
    );

    board_io board_io_i (
        .vdp_clk      (vdp_clk),
        .vdp_reset    (vdp_reset),
        .bus          (periph_bus),
        .status_write (status_write),
        .pad_write    (pad_write),
        .btn_1        (btn_1),
        .btn_2        (btn_2),
        .btn_3        (btn_3),
        .led_r        (led_r),
        .led_b        (led_b),
        .status       (status),
        .pad_bit      (pad_bit)
    );

    cop_ram cop_ram_i (
        .vdp_clk          (vdp_clk),
        .bus              (periph_bus),
        .cop_write        (cop_write),
        .cop_read_en      (cop_read_en),
        .cop_read_address (cop_read_address),
        .cop_read_data    (cop_read_data)
    );

    bus_arbiter bus_arbiter_i (
        .vdp_clk       (vdp_clk),
        .vdp_reset     (vdp_reset),
        .region        (region),
        .sel           (sel),
        .dsp_result    (dsp_result),
        .status        (status),
        .pad_bit       (pad_bit),
        .cpu_ready     (cpu_ready),
        .cpu_read_data (cpu_read_data)
    );

endmodule

/* verification/periph_bus_checker.sv */
// bus protocol assertions for the peripheral subsystem
// bound to the top level, watches the ready pulse and the LEDs after reset

`timescale 1ns/1ps

module periph_bus_checker (
    input logic vdp_clk,
    input logic vdp_reset,
    input logic cpu_valid,
    input logic cpu_ready,
    input logic led_r,
    input logic led_b
);

    // read by the testbench at the end of the run
    int failure_count = 0;

    ready_needs_valid: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset) cpu_ready |-> cpu_valid
    ) else begin
        $error("cpu_ready high without cpu_valid");
        failure_count++;
    end

    ready_single_pulse: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset) cpu_ready |=> !cpu_ready
    ) else begin
        $error("cpu_ready held for more than one cycle");
        failure_count++;
    end

    // decoder stage plus arbiter stage
    ready_latency: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset)
            $rose(cpu_valid) |-> !cpu_ready ##1 !cpu_ready ##1 cpu_ready
    ) else begin
        $error("cpu_ready not exactly 2 cycles after cpu_valid");
        failure_count++;
    end

    leds_after_reset: assert property (
        @(posedge vdp_clk) $fell(vdp_reset) |-> (led_r && !led_b)
    ) else begin
        $error("LEDs not at red on, blue off after reset");
        failure_count++;
    end

endmodule

bind periph_subsystem periph_bus_checker periph_bus_checker_i (
    .vdp_clk   (vdp_clk),
    .vdp_reset (vdp_reset),
    .cpu_valid (cpu_valid),
    .cpu_ready (cpu_ready),
    .led_r     (led_r),
    .led_b     (led_b)
);

/* verification/periph_subsystem_tb.sv */
// testbench for the peripheral subsystem
// bus tasks, LFSR stimulus, register model with reference read function,
// read compare, ready latency monitor and cycle timeout

`timescale 1ns/1ps

module periph_subsystem_tb;

    localparam int num_transactions = 1 + 40 * 3 + 2 + 2 + 16 * 3 + 30 + 30 + 5;
    localparam int timeout_cycles   = num_transactions * 6 + 50;

    logic        vdp_clk;
    logic        vdp_reset;
    logic [23:0] cpu_address;
    logic [31:0] cpu_write_data;
    logic [3:0]  cpu_wstrb;
    logic        cpu_valid;
    logic        cpu_ready;
    logic [31:0] cpu_read_data;
    logic        btn_1;
    logic        btn_2;
    logic        btn_3;
    logic        led_r;
    logic        led_b;
    logic        cop_read_en;
    logic [10:0] cop_read_address;
    logic [15:0] cop_read_data;

    // register model
    logic signed [15:0] op_a;
    logic signed [15:0] op_b;
    logic [1:0]         status_m;
    logic               pad_clk_m;
    logic               pad_b1;
    logic               pad_b2;
    logic               pad_b3;
    int                 pad_index;
    logic [15:0]        cop_m [0:2047];
    logic [10:0]        cop_written [$];

    logic [31:0] expected_q [$];
    logic [31:0] expected_word;
    logic [15:0] lfsr_state;
    logic        valid_q;
    int          latency;
    int          error_count;
    int          reads_checked;
    int          cycle_count;

    periph_subsystem periph_subsystem_i (.*);

    initial begin
        vdp_clk = 1'b0;
        forever #50 vdp_clk = ~vdp_clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    function automatic logic [31:0] ref_read(input logic [23:0] address);
        logic signed [31:0] product;
        logic               pad;
        product = op_a * op_b;
        // serial order is btn_2, five zeros, btn_3, btn_1, then zeros
        if (pad_index == 0) begin
            pad = pad_b2;
        end else if (pad_index == 6) begin
            pad = pad_b3;
        end else if (pad_index == 7) begin
            pad = pad_b1;
        end else begin
            pad = 1'b0;
        end
        case (address[19:16])
            4'd1:    return product;
            4'd2:    return {30'd0, status_m};
            4'd3:    return {31'd0, pad};
            default: return 32'd0;
        endcase
    endfunction

    task automatic update_model(input logic [23:0] address, input logic [31:0] data,
                                input logic [3:0] wstrb);
        case (address[19:16])
            4'd1: begin
                if (address[2]) begin
                    op_b = data[15:0];
                end else begin
                    op_a = data[15:0];
                end
            end
            4'd2: status_m = data[1:0];
            4'd3: begin
                if (data[1] && !pad_clk_m) begin
                    pad_index++;
                end else if (data[0]) begin
                    pad_index = 0;
                    pad_b1 = btn_1;
                    pad_b2 = btn_2;
                    pad_b3 = btn_3;
                end
                pad_clk_m = data[1];
            end
            4'd4: begin
                cop_m[{address[11:2], wstrb[2]}] = data[15:0];
                cop_written.push_back({address[11:2], wstrb[2]});
            end
            default: ;
        endcase
    endtask

    task automatic bus_access(input logic [23:0] address, input logic [31:0] data,
                              input logic [3:0] wstrb);
        int waited;
        @(negedge vdp_clk);
        cpu_address    = address;
        cpu_write_data = data;
        cpu_wstrb      = wstrb;
        cpu_valid      = 1'b1;
        waited = 0;
        do begin
            @(negedge vdp_clk);
            waited++;
        end while (cpu_ready !== 1'b1 && waited < 8);
        if (cpu_ready !== 1'b1) begin
            $display("request to address %h never got a ready pulse", address);
            error_count++;
        end
        // valid drops in the cycle after the ready pulse
        @(negedge vdp_clk);
        cpu_valid = 1'b0;
        cpu_wstrb = 4'h0;
    endtask

    task automatic bus_write(input logic [23:0] address, input logic [31:0] data,
                             input logic [3:0] wstrb);
        update_model(address, data, wstrb);
        bus_access(address, data, wstrb);
    endtask

    task automatic bus_read(input logic [23:0] address);
        expected_q.push_back(ref_read(address));
        bus_access(address, 32'd0, 4'h0);
    endtask

    task automatic check_leds(input logic [1:0] expected);
        if (led_r !== expected[0]) begin
            $display("ERROR led_r expected %h got %h", expected[0], led_r);
            error_count++;
        end
        if (led_b !== expected[1]) begin
            $display("ERROR led_b expected %h got %h", expected[1], led_b);
            error_count++;
        end
    endtask

    task automatic display_read_check(input logic [10:0] address);
        @(negedge vdp_clk);
        cop_read_en      = 1'b1;
        cop_read_address = address;
        @(negedge vdp_clk);
        cop_read_en = 1'b0;
        if (cop_read_data !== cop_m[address]) begin
            $display("ERROR cop_read_data at %h expected %h got %h",
                     address, cop_m[address], cop_read_data);
            error_count++;
        end
    endtask

    // compare every completed read against the model
    always @(posedge vdp_clk) begin
        if (!vdp_reset && cpu_ready === 1'b1 && cpu_wstrb == 4'h0) begin
            if (expected_q.size() == 0) begin
                $display("a read completed that was never issued");
                error_count++;
            end else begin
                expected_word = expected_q.pop_front();
                reads_checked++;
                if (cpu_read_data !== expected_word) begin
                    $display("ERROR cpu_read_data expected %h got %h",
                             expected_word, cpu_read_data);
                    error_count++;
                end
            end
        end
    end

    // ready latency counted from the first cycle of valid
    always @(posedge vdp_clk) begin
        if (vdp_reset) begin
            valid_q = 1'b0;
        end else begin
            if (cpu_valid && !valid_q) begin
                latency = 0;
            end else begin
                latency++;
            end
            if (cpu_ready === 1'b1 && latency != 2) begin
                $display("ready came %0d cycles after valid instead of 2", latency);
                error_count++;
            end
            valid_q = cpu_valid;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge vdp_clk);
            cycle_count++;
        end
        $display("run did not finish within %0d cycles", timeout_cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [1:0]  led_value;
        logic [10:0] word;
        vdp_reset        = 1'b1;
        cpu_address      = '0;
        cpu_write_data   = '0;
        cpu_wstrb        = '0;
        cpu_valid        = 1'b0;
        btn_1            = 1'b0;
        btn_2            = 1'b0;
        btn_3            = 1'b0;
        cop_read_en      = 1'b0;
        cop_read_address = '0;
        lfsr_state       = 16'd29976;
        error_count      = 0;
        reads_checked    = 0;
        status_m         = periph_pkg::status_reset_value;
        pad_clk_m        = 1'b0;
        pad_index        = 0;
        repeat (4) @(posedge vdp_clk);
        @(negedge vdp_clk);
        vdp_reset = 1'b0;

        check_leds(periph_pkg::status_reset_value);
        bus_read(24'h020000);

        for (int i = 0; i < 40; i++) begin
            bus_write(24'h010000, {16'h0000, 16'(random_bits(16))}, 4'hF);
            bus_write(24'h010004, {16'h0000, 16'(random_bits(16))}, 4'hF);
            bus_read(24'h010000);
        end

        // a value other than the current one, so the write shows
        do begin
            led_value = 2'(random_bits(2));
        end while (led_value == status_m);
        bus_write(24'h020000, {30'd0, led_value}, 4'hF);
        check_leds(led_value);
        bus_read(24'h020000);

        @(negedge vdp_clk);
        // at least one button pressed so the load is visible
        do begin
            {btn_1, btn_2, btn_3} = 3'(random_bits(3));
        end while ({btn_1, btn_2, btn_3} == 3'b000);
        bus_write(24'h030000, 32'h1, 4'hF);
        bus_write(24'h030000, 32'h0, 4'hF);
        for (int i = 0; i < 16; i++) begin
            bus_read(24'h030000);
            bus_write(24'h030000, 32'h2, 4'hF);
            bus_write(24'h030000, 32'h0, 4'hF);
        end

        // word address bit 0 travels in wstrb bit 2
        for (int i = 0; i < 30; i++) begin
            word = 11'(random_bits(11));
            bus_write({8'h04, 4'h0, word[10:1], 2'b00}, {16'h0000, 16'(random_bits(16))},
                      word[0] ? 4'b1100 : 4'b0011);
        end
        foreach (cop_written[i]) begin
            display_read_check(cop_written[i]);
        end

        bus_read(24'h000000);
        bus_read(24'h050000);
        bus_read(24'h0F0008);
        bus_read(24'hFA0004);
        bus_read(24'h040000);

        if (expected_q.size() != 0) begin
            $display("%0d reads were issued but never completed", expected_q.size());
            error_count++;
        end
        error_count += periph_subsystem_i.periph_bus_checker_i.failure_count;
        $display("%0d errors, %0d reads checked", error_count, reads_checked);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
